/* hw/lsq_pkg.sv */
`default_nettype none

package lsq_pkg;

    ////////////////////////////////////////////////////////////
    // Queue geometry
    ////////////////////////////////////////////////////////////

    localparam int BANK_NUM     = 2;
    localparam int BANK_SIZE    = 8;
    localparam int SLOT_WIDTH   = 3;
    localparam int PREG_WIDTH   = 6;
    localparam int WAKEUP_PORTS = 2;
    localparam int ROB_WIDTH    = 5;
    localparam int LQ_WIDTH     = 4;

    // Wide enough to hold a full bank, and all banks together.
    localparam int COUNT_WIDTH  = $clog2(BANK_SIZE + 1);
    localparam int OCC_WIDTH    = $clog2(BANK_NUM * BANK_SIZE + 1);

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                 dir;
        logic [ROB_WIDTH-1:0] idx;
    } rob_idx_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [PREG_WIDTH-1:0] rd;
        logic [LQ_WIDTH-1:0]   lq_idx;
        rob_idx_t              rob_idx;
        logic [1:0]            size;
    } load_payload_t;

    // True when a is younger than b. The direction bit flips each time
    // the reorder buffer wraps, which reverses the index order.
    function automatic logic rob_younger(input rob_idx_t a, input rob_idx_t b);
        if (a.dir == b.dir) begin
            return a.idx > b.idx;
        end
        return a.idx < b.idx;
    endfunction

endpackage

`default_nettype wire

/* hw/load_bank_if.sv */
`default_nettype none

// Connects one issue bank to the merge stage.
interface load_bank_if import lsq_pkg::*; ();

    logic                   sel_valid;
    logic [SLOT_WIDTH-1:0]  sel_slot;
    load_payload_t          sel_payload;
    logic                   full;
    logic [COUNT_WIDTH-1:0] count;

    // Shared across banks, so a bank stops taking loads when any bank is full.
    logic                   dis_full;

    modport bank (
        output sel_valid,
        output sel_slot,
        output sel_payload,
        output full,
        output count,
        input  dis_full
    );

    modport merge (
        input  sel_valid,
        input  sel_slot,
        input  sel_payload,
        input  full,
        input  count,
        output dis_full
    );

endinterface

`default_nettype wire

/* hw/load_issue_bank.sv */
`default_nettype none

module load_issue_bank import lsq_pkg::*; #(
    parameter int unsigned BANK_ID = 0
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    dis_valid_i,
    input  logic                                    dis_rs1_ready_i,
    input  logic [PREG_WIDTH-1:0]                   dis_rs1_i,
    input  load_payload_t                           dis_payload_i,
    input  logic [WAKEUP_PORTS-1:0]                 wakeup_valid_i,
    input  logic [WAKEUP_PORTS-1:0][PREG_WIDTH-1:0] wakeup_preg_i,
    input  logic                                    reply_valid_i,
    input  logic [SLOT_WIDTH-1:0]                   reply_slot_i,
    input  logic                                    success_valid_i,
    input  logic [SLOT_WIDTH-1:0]                   success_slot_i,
    input  logic                                    redirect_i,
    input  rob_idx_t                                redirect_rob_i,
    load_bank_if.bank                               io
);

    logic [BANK_SIZE-1:0]   valid_q;
    logic [BANK_SIZE-1:0]   ready_q;
    logic [BANK_SIZE-1:0]   issued_q;
    logic [PREG_WIDTH-1:0]  rs1_q [BANK_SIZE];
    load_payload_t          payload_q [BANK_SIZE];

    logic [BANK_SIZE-1:0]   wake_hit;
    logic [BANK_SIZE-1:0]   flush_mask;
    logic [BANK_SIZE-1:0]   cand;
    logic [BANK_SIZE-1:0]   alloc_mask;
    logic [BANK_SIZE-1:0]   sel_mask;
    logic [BANK_SIZE-1:0]   reply_mask;
    logic [BANK_SIZE-1:0]   success_mask;
    logic                   alloc;
    logic                   dis_ready;
    logic [SLOT_WIDTH-1:0]  alloc_slot;
    logic [SLOT_WIDTH-1:0]  sel_slot;
    logic [COUNT_WIDTH-1:0] count;

    // Index of the lowest set bit; zero when the mask is empty.
    function automatic logic [SLOT_WIDTH-1:0] lowest_slot(input logic [BANK_SIZE-1:0] mask);
        logic [SLOT_WIDTH-1:0] idx;
        idx = '0;
        for (int i = BANK_SIZE - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = SLOT_WIDTH'(i);
            end
        end
        return idx;
    endfunction

    function automatic logic [BANK_SIZE-1:0] slot_onehot(input logic en,
                                                          input logic [SLOT_WIDTH-1:0] slot);
        return en ? (BANK_SIZE'(1) << slot) : '0;
    endfunction

    ////////////////////////////////////////////////////////////
    // Allocation, wakeup and selection
    ////////////////////////////////////////////////////////////

    // The low bit of the load-queue index steers a load to its bank.
    assign alloc = dis_valid_i && !io.dis_full && (dis_payload_i.lq_idx[0] == 1'(BANK_ID));
    assign alloc_slot = lowest_slot(~valid_q);
    assign cand = valid_q & ready_q & ~issued_q;
    assign sel_slot = lowest_slot(cand);

    always_comb begin
        dis_ready = dis_rs1_ready_i;
        for (int j = 0; j < WAKEUP_PORTS; j++) begin
            if (wakeup_valid_i[j] && (wakeup_preg_i[j] == dis_rs1_i)) begin
                dis_ready = 1'b1;
            end
        end
        for (int i = 0; i < BANK_SIZE; i++) begin
            wake_hit[i] = 1'b0;
            for (int j = 0; j < WAKEUP_PORTS; j++) begin
                if (wakeup_valid_i[j] && (wakeup_preg_i[j] == rs1_q[i])) begin
                    wake_hit[i] = 1'b1;
                end
            end
            flush_mask[i] = redirect_i && rob_younger(payload_q[i].rob_idx, redirect_rob_i);
        end
    end

    always_comb begin
        count = '0;
        for (int i = 0; i < BANK_SIZE; i++) begin
            count = count + COUNT_WIDTH'(valid_q[i]);
        end
    end

    assign alloc_mask   = slot_onehot(alloc, alloc_slot);
    assign sel_mask     = slot_onehot(io.sel_valid, sel_slot);
    assign reply_mask   = slot_onehot(reply_valid_i, reply_slot_i);
    assign success_mask = slot_onehot(success_valid_i, success_slot_i);

    // Nothing leaves the bank in a redirect cycle.
    assign io.sel_valid   = (|cand) && !redirect_i;
    assign io.sel_slot    = sel_slot;
    assign io.sel_payload = payload_q[sel_slot];
    assign io.full        = &valid_q;
    assign io.count       = count;

    ////////////////////////////////////////////////////////////
    // Entry state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q  <= '0;
            ready_q  <= '0;
            issued_q <= '0;
        end else begin
            valid_q  <= (valid_q & ~flush_mask & ~success_mask) | alloc_mask;
            ready_q  <= ((ready_q | wake_hit) & ~alloc_mask) |
                        (alloc_mask & {BANK_SIZE{dis_ready}});
            // An issued entry stays put until success, or comes back on replay.
            issued_q <= (issued_q | sel_mask) & ~reply_mask & ~alloc_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rs1_q[alloc_slot]     <= dis_rs1_i;
            payload_q[alloc_slot] <= dis_payload_i;
        end
    end

    // The shared full flag from the merge stage must keep a full bank closed.
    a_no_alloc_when_full: assert property (
        @(posedge clk) disable iff (rst) alloc |-> !io.full
    );

    a_success_valid_entry: assert property (
        @(posedge clk) disable iff (rst) success_valid_i |-> valid_q[success_slot_i]
    );

    a_reply_valid_entry: assert property (
        @(posedge clk) disable iff (rst) reply_valid_i |-> valid_q[reply_slot_i]
    );

endmodule

`default_nettype wire

/* hw/load_issue_merge.sv */
`default_nettype none

module load_issue_merge import lsq_pkg::*; (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  redirect_i,
    input  rob_idx_t                              redirect_rob_i,
    load_bank_if.merge                            bank0,
    load_bank_if.merge                            bank1,
    output logic [BANK_NUM-1:0]                   issue_valid_o,
    output logic [BANK_NUM-1:0][SLOT_WIDTH-1:0]   issue_slot_o,
    output load_payload_t [BANK_NUM-1:0]          issue_payload_o,
    output logic                                  dis_full_o,
    output logic [OCC_WIDTH-1:0]                  occupancy_o
);

    logic [BANK_NUM-1:0]                 sel_valid;
    logic [BANK_NUM-1:0][SLOT_WIDTH-1:0] sel_slot;
    load_payload_t [BANK_NUM-1:0]        sel_payload;
    logic [BANK_NUM-1:0]                 kill;
    logic                                dis_full;

    assign sel_valid   = {bank1.sel_valid, bank0.sel_valid};
    assign sel_slot    = {bank1.sel_slot, bank0.sel_slot};
    assign sel_payload = {bank1.sel_payload, bank0.sel_payload};

    always_comb begin
        for (int i = 0; i < BANK_NUM; i++) begin
            kill[i] = redirect_i && rob_younger(sel_payload[i].rob_idx, redirect_rob_i);
        end
    end

    ////////////////////////////////////////////////////////////
    // Issue lanes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_valid_o <= '0;
        end else begin
            issue_valid_o <= sel_valid & ~kill;
        end
    end

    always_ff @(posedge clk) begin
        issue_slot_o    <= sel_slot;
        issue_payload_o <= sel_payload;
    end

    ////////////////////////////////////////////////////////////
    // Shared dispatch state
    ////////////////////////////////////////////////////////////

    assign dis_full       = bank0.full | bank1.full;
    assign bank0.dis_full = dis_full;
    assign bank1.dis_full = dis_full;
    assign dis_full_o     = dis_full;

    assign occupancy_o = OCC_WIDTH'(bank0.count) + OCC_WIDTH'(bank1.count);

    a_occupancy_bound: assert property (
        @(posedge clk) disable iff (rst) occupancy_o <= OCC_WIDTH'(BANK_NUM * BANK_SIZE)
    );

endmodule

`default_nettype wire

/* hw/load_issue_queue.sv */
`default_nettype none

module load_issue_queue import lsq_pkg::*; (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    dis_valid_i,
    input  logic                                    dis_rs1_ready_i,
    input  logic [PREG_WIDTH-1:0]                   dis_rs1_i,
    input  load_payload_t                           dis_payload_i,
    input  logic [WAKEUP_PORTS-1:0]                 wakeup_valid_i,
    input  logic [WAKEUP_PORTS-1:0][PREG_WIDTH-1:0] wakeup_preg_i,
    input  logic [BANK_NUM-1:0]                     reply_valid_i,
    input  logic [BANK_NUM-1:0][SLOT_WIDTH-1:0]     reply_slot_i,
    input  logic [BANK_NUM-1:0]                     success_valid_i,
    input  logic [BANK_NUM-1:0][SLOT_WIDTH-1:0]     success_slot_i,
    input  logic                                    redirect_i,
    input  rob_idx_t                                redirect_rob_i,
    output logic                                    dis_full_o,
    output logic [BANK_NUM-1:0]                     issue_valid_o,
    output logic [BANK_NUM-1:0][SLOT_WIDTH-1:0]     issue_slot_o,
    output load_payload_t [BANK_NUM-1:0]            issue_payload_o,
    output logic [OCC_WIDTH-1:0]                    occupancy_o
);

    load_bank_if bank0_if ();
    load_bank_if bank1_if ();

    // Lane i of every outcome port belongs to bank i.
    load_issue_bank #(
        .BANK_ID(0)
    ) i_bank0 (
        .clk             (clk),
        .rst             (rst),
        .dis_valid_i     (dis_valid_i),
        .dis_rs1_ready_i (dis_rs1_ready_i),
        .dis_rs1_i       (dis_rs1_i),
        .dis_payload_i   (dis_payload_i),
        .wakeup_valid_i  (wakeup_valid_i),
        .wakeup_preg_i   (wakeup_preg_i),
        .reply_valid_i   (reply_valid_i[0]),
        .reply_slot_i    (reply_slot_i[0]),
        .success_valid_i (success_valid_i[0]),
        .success_slot_i  (success_slot_i[0]),
        .redirect_i      (redirect_i),
        .redirect_rob_i  (redirect_rob_i),
        .io              (bank0_if.bank)
    );

    load_issue_bank #(
        .BANK_ID(1)
    ) i_bank1 (
        .clk             (clk),
        .rst             (rst),
        .dis_valid_i     (dis_valid_i),
        .dis_rs1_ready_i (dis_rs1_ready_i),
        .dis_rs1_i       (dis_rs1_i),
        .dis_payload_i   (dis_payload_i),
        .wakeup_valid_i  (wakeup_valid_i),
        .wakeup_preg_i   (wakeup_preg_i),
        .reply_valid_i   (reply_valid_i[1]),
        .reply_slot_i    (reply_slot_i[1]),
        .success_valid_i (success_valid_i[1]),
        .success_slot_i  (success_slot_i[1]),
        .redirect_i      (redirect_i),
        .redirect_rob_i  (redirect_rob_i),
        .io              (bank1_if.bank)
    );

    load_issue_merge i_merge (
        .clk             (clk),
        .rst             (rst),
        .redirect_i      (redirect_i),
        .redirect_rob_i  (redirect_rob_i),
        .bank0           (bank0_if.merge),
        .bank1           (bank1_if.merge),
        .issue_valid_o   (issue_valid_o),
        .issue_slot_o    (issue_slot_o),
        .issue_payload_o (issue_payload_o),
        .dis_full_o      (dis_full_o),
        .occupancy_o     (occupancy_o)
    );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Reset is released a quarter period after a rising edge.
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #(PERIOD / 4);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* sim/tb_load_issue_queue.sv */
`default_nettype none

module tb_load_issue_queue import lsq_pkg::*; ();

    localparam int ISSUE_TIMEOUT = 12;
    localparam int QUIET_EDGES   = 5;
    localparam int RESET_TIMEOUT = 40;
    localparam int ISSUE_LATENCY = 2;

    typedef enum int {
        OP_DISPATCH, OP_WAKEUP, OP_REPLAY, OP_SUCCESS, OP_REDIRECT, OP_CHECK
    } op_kind_e;

    // Dispatch uses a as lq index, b as rs1, c as ready and d as rob index.
    // Wakeup uses a as preg and b as port. Replay and success use a as lane and b as slot.
    // Redirect uses d as rob index. Check expects occupancy a and full flag b.
    typedef struct {
        string    name;
        op_kind_e kind;
        int       a;
        int       b;
        int       c;
        int       d;
    } op_row_t;

    logic                                    clk;
    logic                                    rst;
    logic                                    dis_valid;
    logic                                    dis_rs1_ready;
    logic [PREG_WIDTH-1:0]                   dis_rs1;
    load_payload_t                           dis_payload;
    logic [WAKEUP_PORTS-1:0]                 wakeup_valid;
    logic [WAKEUP_PORTS-1:0][PREG_WIDTH-1:0] wakeup_preg;
    logic [BANK_NUM-1:0]                     reply_valid;
    logic [BANK_NUM-1:0][SLOT_WIDTH-1:0]     reply_slot;
    logic [BANK_NUM-1:0]                     success_valid;
    logic [BANK_NUM-1:0][SLOT_WIDTH-1:0]     success_slot;
    logic                                    redirect;
    rob_idx_t                                redirect_rob;
    logic                                    dis_full;
    logic [BANK_NUM-1:0]                     issue_valid;
    logic [BANK_NUM-1:0][SLOT_WIDTH-1:0]     issue_slot;
    load_payload_t [BANK_NUM-1:0]            issue_payload;
    logic [OCC_WIDTH-1:0]                    occupancy;

    op_row_t       table_q [$];
    int            errors;
    int            checks;
    int            tests;

    // Reference model of every entry.
    bit            m_valid   [BANK_NUM][BANK_SIZE];
    bit            m_ready   [BANK_NUM][BANK_SIZE];
    bit            m_issued  [BANK_NUM][BANK_SIZE];
    int            m_rs1     [BANK_NUM][BANK_SIZE];
    load_payload_t m_payload [BANK_NUM][BANK_SIZE];

    tb_clock #(.PERIOD(40), .RESET_CYCLES(10)) i_clock (.clk_o(clk), .rst_o(rst));

    load_issue_queue i_dut (
        .clk             (clk),
        .rst             (rst),
        .dis_valid_i     (dis_valid),
        .dis_rs1_ready_i (dis_rs1_ready),
        .dis_rs1_i       (dis_rs1),
        .dis_payload_i   (dis_payload),
        .wakeup_valid_i  (wakeup_valid),
        .wakeup_preg_i   (wakeup_preg),
        .reply_valid_i   (reply_valid),
        .reply_slot_i    (reply_slot),
        .success_valid_i (success_valid),
        .success_slot_i  (success_slot),
        .redirect_i      (redirect),
        .redirect_rob_i  (redirect_rob),
        .dis_full_o      (dis_full),
        .issue_valid_o   (issue_valid),
        .issue_slot_o    (issue_slot),
        .issue_payload_o (issue_payload),
        .occupancy_o     (occupancy)
    );

    ////////////////////////////////////////////////////////////
    // Model helpers
    ////////////////////////////////////////////////////////////

    // A different direction bit means the reorder buffer wrapped in between.
    function automatic bit is_younger(input rob_idx_t a, input rob_idx_t b);
        if (a.dir != b.dir) begin
            return a.idx < b.idx;
        end
        return a.idx > b.idx;
    endfunction

    function automatic int lowest_free(input int bank);
        for (int s = 0; s < BANK_SIZE; s++) begin
            if (!m_valid[bank][s]) begin
                return s;
            end
        end
        return -1;
    endfunction

    function automatic int lowest_ready(input int bank);
        for (int s = 0; s < BANK_SIZE; s++) begin
            if (m_valid[bank][s] && m_ready[bank][s] && !m_issued[bank][s]) begin
                return s;
            end
        end
        return -1;
    endfunction

    function automatic int model_count();
        int n;
        n = 0;
        for (int b = 0; b < BANK_NUM; b++) begin
            for (int s = 0; s < BANK_SIZE; s++) begin
                n += int'(m_valid[b][s]);
            end
        end
        return n;
    endfunction

    function automatic bit model_full();
        bit full;
        full = 1'b0;
        for (int b = 0; b < BANK_NUM; b++) begin
            if (lowest_free(b) < 0) begin
                full = 1'b1;
            end
        end
        return full;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus and checks
    ////////////////////////////////////////////////////////////

    task automatic step();
        @(posedge clk);
        #5;
    endtask

    task automatic clear_inputs();
        dis_valid     = 1'b0;
        dis_rs1_ready = 1'b0;
        dis_rs1       = '0;
        dis_payload   = '0;
        wakeup_valid  = '0;
        wakeup_preg   = '0;
        reply_valid   = '0;
        reply_slot    = '0;
        success_valid = '0;
        success_slot  = '0;
        redirect      = 1'b0;
        redirect_rob  = '0;
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (exp == act) else begin
            $display("FAILED %s %s: expected %0h, actual %0h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic add_row(input string name, input op_kind_e kind,
                           input int a, input int b, input int c, input int d);
        op_row_t row;
        row.name = name;
        row.kind = kind;
        row.a    = a;
        row.b    = b;
        row.c    = c;
        row.d    = d;
        table_q.push_back(row);
    endtask

    // The model picks the lane and slot; the issue must come on the second edge.
    task automatic watch_issue(input string name);
        int lane;
        int slot;
        int edge_n;
        int limit;
        bit seen;
        lane = -1;
        slot = 0;
        seen = 1'b0;
        for (int b = 0; b < BANK_NUM; b++) begin
            if (lane < 0 && lowest_ready(b) >= 0) begin
                lane = b;
                slot = lowest_ready(b);
            end
        end
        limit  = (lane < 0) ? QUIET_EDGES : ISSUE_TIMEOUT;
        edge_n = 1;
        while (!seen && edge_n < limit) begin
            step();
            edge_n++;
            if (issue_valid != '0) begin
                seen = 1'b1;
            end
        end
        if (lane < 0) begin
            assert (!seen) else begin
                $display("%s: unexpected issue on lanes %b at edge %0d",
                         name, issue_valid, edge_n);
                errors++;
            end
        end else begin
            assert (seen) else begin
                $display("%s: no issue on lane %0d within %0d edges", name, lane, limit);
                errors++;
            end
            if (seen) begin
                check_value(name, "issue edge", ISSUE_LATENCY, edge_n);
                check_value(name, "issue lanes", 1 << lane, issue_valid);
                check_value(name, "issue slot", slot, issue_slot[lane]);
                check_value(name, "issue payload", m_payload[lane][slot], issue_payload[lane]);
                m_issued[lane][slot] = 1'b1;
            end
        end
    endtask

    task automatic apply_row(input op_row_t row);
        int bank;
        int slot;
        case (row.kind)
            OP_DISPATCH: begin
                dis_valid           = 1'b1;
                dis_rs1_ready       = 1'(row.c);
                dis_rs1             = PREG_WIDTH'(row.b);
                dis_payload.imm     = 12'($urandom);
                dis_payload.rd      = PREG_WIDTH'($urandom);
                dis_payload.lq_idx  = LQ_WIDTH'(row.a);
                dis_payload.rob_idx = rob_idx_t'(6'(row.d));
                dis_payload.size    = 2'(row.a);
                if (!model_full()) begin
                    bank = row.a % BANK_NUM;
                    slot = lowest_free(bank);
                    m_valid[bank][slot]   = 1'b1;
                    m_ready[bank][slot]   = row.c != 0;
                    m_issued[bank][slot]  = 1'b0;
                    m_rs1[bank][slot]     = row.b;
                    m_payload[bank][slot] = dis_payload;
                end
            end
            OP_WAKEUP: begin
                wakeup_valid[row.b] = 1'b1;
                wakeup_preg[row.b]  = PREG_WIDTH'(row.a);
                for (int b = 0; b < BANK_NUM; b++) begin
                    for (int s = 0; s < BANK_SIZE; s++) begin
                        if (m_valid[b][s] && m_rs1[b][s] == row.a) begin
                            m_ready[b][s] = 1'b1;
                        end
                    end
                end
            end
            OP_REPLAY: begin
                reply_valid[row.a]  = 1'b1;
                reply_slot[row.a]   = SLOT_WIDTH'(row.b);
                m_issued[row.a][row.b] = 1'b0;
            end
            OP_SUCCESS: begin
                success_valid[row.a] = 1'b1;
                success_slot[row.a]  = SLOT_WIDTH'(row.b);
                m_valid[row.a][row.b] = 1'b0;
            end
            OP_REDIRECT: begin
                redirect     = 1'b1;
                redirect_rob = rob_idx_t'(6'(row.d));
                for (int b = 0; b < BANK_NUM; b++) begin
                    for (int s = 0; s < BANK_SIZE; s++) begin
                        if (m_valid[b][s] &&
                            is_younger(m_payload[b][s].rob_idx, redirect_rob)) begin
                            m_valid[b][s] = 1'b0;
                        end
                    end
                end
            end
            default: begin
            end
        endcase
        step();
        clear_inputs();
        if (row.kind == OP_CHECK) begin
            check_value(row.name, "occupancy", row.a, occupancy);
            check_value(row.name, "dispatch full", row.b, dis_full);
            check_value(row.name, "issue lanes", 0, issue_valid);
        end else begin
            watch_issue(row.name);
        end
    endtask

    task automatic build_table();
        add_row("after_reset",  OP_CHECK,    0, 0, 0, 0);
        add_row("ready_lane0",  OP_DISPATCH, 2, 1, 1, 'h01);
        add_row("ready_lane1",  OP_DISPATCH, 5, 2, 1, 'h02);
        add_row("wait_load",    OP_DISPATCH, 4, 10, 0, 'h03);
        add_row("wake_other",   OP_WAKEUP,   11, 0, 0, 0);
        add_row("wake_own",     OP_WAKEUP,   10, 1, 0, 0);
        add_row("replay",       OP_REPLAY,   0, 1, 0, 0);
        add_row("success",      OP_SUCCESS,  0, 1, 0, 0);
        add_row("occ_after_ok", OP_CHECK,    2, 0, 0, 0);
        add_row("drain_lane0",  OP_SUCCESS,  0, 0, 0, 0);
        add_row("drain_lane1",  OP_SUCCESS,  1, 0, 0, 0);
        for (int i = 0; i < BANK_SIZE; i++) begin
            add_row($sformatf("fill_%0d", i), OP_DISPATCH, 2 * i + 1, 20 + i, 0, 4 + i);
        end
        add_row("full_flag",    OP_CHECK,    8, 1, 0, 0);
        add_row("ninth_offer",  OP_DISPATCH, 0, 30, 1, 'h0C);
        add_row("still_full",   OP_CHECK,    8, 1, 0, 0);
        add_row("free_one",     OP_SUCCESS,  1, 3, 0, 0);
        add_row("not_full",     OP_CHECK,    7, 0, 0, 0);
        // Rob 0x21 and 0x22 sit past the wrap and are younger than 0x08.
        add_row("old_side",     OP_DISPATCH, 2, 40, 0, 'h1E);
        add_row("wrapped_0",    OP_DISPATCH, 4, 41, 0, 'h21);
        add_row("wrapped_1",    OP_DISPATCH, 3, 42, 0, 'h22);
        add_row("redirect",     OP_REDIRECT, 0, 0, 0, 'h08);
        add_row("after_flush",  OP_CHECK,    4, 0, 0, 0);
        add_row("wake_s0",      OP_WAKEUP,   20, 0, 0, 0);
        add_row("wake_s1",      OP_WAKEUP,   21, 1, 0, 0);
        add_row("wake_s2",      OP_WAKEUP,   22, 0, 0, 0);
        add_row("wake_flushed", OP_WAKEUP,   25, 0, 0, 0);
        add_row("wake_s4",      OP_WAKEUP,   24, 1, 0, 0);
        add_row("end_state",    OP_CHECK,    4, 0, 0, 0);
    endtask

    initial begin
        int seed_state;
        int wait_n;
        int row_errors;
        seed_state = $urandom(42990);
        errors = 0;
        checks = 0;
        tests  = 0;
        clear_inputs();
        build_table();
        wait_n = 0;
        do begin
            step();
            wait_n++;
        end while (rst && wait_n < RESET_TIMEOUT);
        assert (!rst) else begin
            $display("Reset still active after %0d cycles", RESET_TIMEOUT);
            errors++;
        end
        foreach (table_q[i]) begin
            row_errors = errors;
            apply_row(table_q[i]);
            check_value(table_q[i].name, "occupancy vs model", model_count(), occupancy);
            tests++;
            if (errors == row_errors) begin
                $display("%s: ok", table_q[i].name);
            end else begin
                $display("%s: %0d errors", table_q[i].name, errors - row_errors);
            end
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/lsq_pkg.sv
hw/load_bank_if.sv
hw/load_issue_bank.sv
hw/load_issue_merge.sv
hw/load_issue_queue.sv
sim/tb_clock.sv
sim/tb_load_issue_queue.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_load_issue_queue \
    -f verilog.f -o tb_sim > sim.log 2>&1 &&
    ./obj_dir/tb_sim >> sim.log 2>&1
grep -q "^TESTS PASSED$" sim.log && echo "Simulation passed" ||
    { echo "Simulation failed, see sim.log"; exit 1; }
